// ==== soc_pkg.sv ====
package soc_pkg;

  // Bus geometry
  localparam int ADDR_W     = 8;
  localparam int DATA_W     = 32;
  localparam int OFFS_W     = 4;
  localparam int GPIO_MAX_W = 16;

  // Upper address nibble selects the peripheral
  typedef enum logic [3:0] {
    REGION_SYS  = 4'h0,
    REGION_GPIO = 4'h1
  } region_e;

  // System register offsets
  localparam logic [OFFS_W-1:0] SYS_ID      = 4'h0;
  localparam logic [OFFS_W-1:0] SYS_SCRATCH = 4'h1;
  localparam logic [OFFS_W-1:0] SYS_BADCNT  = 4'h2;

  // GPIO register offsets
  localparam logic [OFFS_W-1:0] GPIO_DIR    = 4'h0;
  localparam logic [OFFS_W-1:0] GPIO_OUT    = 4'h1;
  localparam logic [OFFS_W-1:0] GPIO_SETCLR = 4'h2;
  localparam logic [OFFS_W-1:0] GPIO_IN     = 4'h3;

  // Returned on a read of SYS_ID
  localparam logic [DATA_W-1:0] SOC_ID = 32'h5ec0_0c12;

  // Clear mask sits in the upper half
  typedef struct packed {
    logic [GPIO_MAX_W-1:0] clr;
    logic [GPIO_MAX_W-1:0] set;
  } gpio_mask_t;

  typedef union packed {
    logic [DATA_W-1:0] as_value;
    gpio_mask_t        as_mask;
  } gpio_wdata_u;

endpackage

// ==== soc_bus_if.sv ====
`timescale 1ns/100ps

interface periph_req_if;

  logic                        sel_sys;
  logic                        sel_gpio;
  logic                        we;
  logic                        re;
  logic [soc_pkg::OFFS_W-1:0]  offset;
  logic [soc_pkg::DATA_W-1:0]  wdata;
  // Illegal access, never selects a peripheral
  logic                        bad;

  modport dec (
    output sel_sys, sel_gpio, we, re, offset, wdata, bad
  );

  modport periph (
    input sel_sys, sel_gpio, we, re, offset, wdata, bad
  );

  modport mon (
    input re, bad
  );

endinterface

// ==== clk_rst_gen.sv ====
`timescale 1ns/100ps

module clk_rst_gen #(
  parameter int LOCK_CYCLES = 16
) (
  input  logic i_sclk_p,
  input  logic i_sclk_n,
  input  logic i_rst_n,
  output logic o_clk_bus,
  output logic o_bus_nrst,
  output logic o_sys_ready
);

  localparam int CNT_W = $clog2(LOCK_CYCLES + 1);

  logic [CNT_W-1:0] r_lock_cnt;
  logic             r_lock;
  logic             w_pre_nrst;
  logic [1:0]       r_rst_sync;

  // Differential receiver model
  assign o_clk_bus = i_sclk_p;

  // PLL lock delay, counter stops once locked
  always_ff @(posedge o_clk_bus or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_lock_cnt <= '0;
      r_lock     <= 1'b0;
    end else if (!r_lock) begin
      r_lock_cnt <= r_lock_cnt + 1'b1;
      if (r_lock_cnt == CNT_W'(LOCK_CYCLES - 1)) begin
        r_lock <= 1'b1;
      end
    end
  end

  // Board reset or lost lock resets the bus
  assign w_pre_nrst = i_rst_n & r_lock;

  always_ff @(posedge o_clk_bus or negedge w_pre_nrst) begin
    if (!w_pre_nrst) begin
      r_rst_sync <= 2'b00;
    end else begin
      r_rst_sync <= {r_rst_sync[0], 1'b1};
    end
  end

  assign o_bus_nrst  = r_rst_sync[1];
  assign o_sys_ready = r_rst_sync[1];

  a_nrst_until_lock: assert property (
    @(posedge o_clk_bus) disable iff (!i_rst_n) !r_lock |-> !o_bus_nrst
  );

  // Clock pair must stay complementary
  a_clk_diff: assert property (
    @(posedge o_clk_bus) disable iff (!i_rst_n) i_sclk_n != i_sclk_p
  );

endmodule

// ==== bus_decode.sv ====
`timescale 1ns/100ps

module bus_decode (
  input  logic                       i_clk_bus,
  input  logic                       i_rst_n,
  input  logic                       i_we,
  input  logic                       i_re,
  input  logic [soc_pkg::ADDR_W-1:0] i_addr,
  input  logic [soc_pkg::DATA_W-1:0] i_wdata,
  periph_req_if.dec                  req
);

  soc_pkg::region_e           w_region;
  logic [soc_pkg::OFFS_W-1:0] w_offset;
  logic                       w_acc;
  logic                       w_legal;
  logic                       w_is_sys;
  logic                       w_is_gpio;

  assign w_region = soc_pkg::region_e'(i_addr[soc_pkg::ADDR_W-1 -: 4]);
  assign w_offset = i_addr[soc_pkg::OFFS_W-1:0];
  assign w_acc    = i_we | i_re;

  // Register map legality per direction
  always_comb begin
    w_legal   = 1'b0;
    w_is_sys  = 1'b0;
    w_is_gpio = 1'b0;
    case (w_region)
      soc_pkg::REGION_SYS: begin
        w_is_sys = 1'b1;
        case (w_offset)
          soc_pkg::SYS_ID:      w_legal = !i_we;
          soc_pkg::SYS_SCRATCH: w_legal = 1'b1;
          soc_pkg::SYS_BADCNT:  w_legal = !i_we;
          default:              w_legal = 1'b0;
        endcase
      end
      soc_pkg::REGION_GPIO: begin
        w_is_gpio = 1'b1;
        case (w_offset)
          soc_pkg::GPIO_DIR:    w_legal = 1'b1;
          soc_pkg::GPIO_OUT:    w_legal = 1'b1;
          soc_pkg::GPIO_SETCLR: w_legal = i_we;
          soc_pkg::GPIO_IN:     w_legal = !i_we;
          default:              w_legal = 1'b0;
        endcase
      end
      default: w_legal = 1'b0;
    endcase
  end

  // Stage 1 request
  always_ff @(posedge i_clk_bus or negedge i_rst_n) begin
    if (!i_rst_n) begin
      req.we       <= 1'b0;
      req.re       <= 1'b0;
      req.sel_sys  <= 1'b0;
      req.sel_gpio <= 1'b0;
      req.bad      <= 1'b0;
    end else begin
      req.we       <= i_we;
      req.re       <= i_re;
      req.sel_sys  <= w_acc & w_legal & w_is_sys;
      req.sel_gpio <= w_acc & w_legal & w_is_gpio;
      req.bad      <= w_acc & !w_legal;
    end
  end

  always_ff @(posedge i_clk_bus) begin
    req.offset <= w_offset;
    req.wdata  <= i_wdata;
  end

  a_one_strobe: assert property (
    @(posedge i_clk_bus) disable iff (!i_rst_n) !(i_we && i_re)
  );

endmodule

// ==== sys_regs.sv ====
`timescale 1ns/100ps

module sys_regs (
  input  logic                       i_clk_bus,
  input  logic                       i_rst_n,
  periph_req_if.periph               req,
  output logic                       o_ack,
  output logic [soc_pkg::DATA_W-1:0] o_rdata
);

  logic [soc_pkg::DATA_W-1:0] r_scratch;
  logic [soc_pkg::DATA_W-1:0] r_badcnt;
  logic [soc_pkg::DATA_W-1:0] w_rdata;

  always_ff @(posedge i_clk_bus or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_scratch <= '0;
      r_badcnt  <= '0;
      o_ack     <= 1'b0;
    end else begin
      if (req.sel_sys && req.we && (req.offset == soc_pkg::SYS_SCRATCH)) begin
        r_scratch <= req.wdata;
      end
      // Counts every illegal access on the bus, saturating
      if (req.bad && (r_badcnt != '1)) begin
        r_badcnt <= r_badcnt + 1'b1;
      end
      o_ack <= req.sel_sys & req.re;
    end
  end

  always_comb begin
    case (req.offset)
      soc_pkg::SYS_ID:      w_rdata = soc_pkg::SOC_ID;
      soc_pkg::SYS_SCRATCH: w_rdata = r_scratch;
      soc_pkg::SYS_BADCNT:  w_rdata = r_badcnt;
      default:              w_rdata = '0;
    endcase
  end

  always_ff @(posedge i_clk_bus) begin
    o_rdata <= w_rdata;
  end

endmodule

// ==== gpio_regs.sv ====
`timescale 1ns/100ps

module gpio_regs #(
  parameter int GPIO_W = 12
) (
  input  logic                       i_clk_bus,
  input  logic                       i_rst_n,
  periph_req_if.periph               req,
  input  logic [GPIO_W-1:0]          i_gpio,
  output logic [GPIO_W-1:0]          o_gpio,
  output logic [GPIO_W-1:0]          o_gpio_dir,
  output logic                       o_ack,
  output logic [soc_pkg::DATA_W-1:0] o_rdata
);

  soc_pkg::gpio_wdata_u       w_wdata;
  logic [GPIO_W-1:0]          r_dir;
  logic [GPIO_W-1:0]          r_out;
  logic [GPIO_W-1:0]          r_in_meta;
  logic [GPIO_W-1:0]          r_in_sync;
  logic [soc_pkg::DATA_W-1:0] w_rdata;

  assign w_wdata = req.wdata;

  always_ff @(posedge i_clk_bus or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_dir <= '0;
      r_out <= '0;
      o_ack <= 1'b0;
    end else begin
      if (req.sel_gpio && req.we) begin
        case (req.offset)
          soc_pkg::GPIO_DIR: r_dir <= w_wdata.as_value[GPIO_W-1:0];
          soc_pkg::GPIO_OUT: r_out <= w_wdata.as_value[GPIO_W-1:0];
          // Set first, then clear, so clear wins on overlap
          soc_pkg::GPIO_SETCLR: begin
            r_out <= (r_out | w_wdata.as_mask.set[GPIO_W-1:0]) &
                     ~w_wdata.as_mask.clr[GPIO_W-1:0];
          end
          default: r_out <= r_out;
        endcase
      end
      o_ack <= req.sel_gpio & req.re;
    end
  end

  // Two-flop synchronizer on the pins
  always_ff @(posedge i_clk_bus) begin
    r_in_meta <= i_gpio;
    r_in_sync <= r_in_meta;
  end

  always_comb begin
    case (req.offset)
      soc_pkg::GPIO_DIR: w_rdata = soc_pkg::DATA_W'(r_dir);
      soc_pkg::GPIO_OUT: w_rdata = soc_pkg::DATA_W'(r_out);
      soc_pkg::GPIO_IN:  w_rdata = soc_pkg::DATA_W'(r_in_sync);
      default:           w_rdata = '0;
    endcase
  end

  always_ff @(posedge i_clk_bus) begin
    o_rdata <= w_rdata;
  end

  assign o_gpio     = r_out;
  assign o_gpio_dir = r_dir;

  a_gpio_width: assert property (
    @(posedge i_clk_bus) (GPIO_W >= 1) && (GPIO_W <= soc_pkg::GPIO_MAX_W)
  );

endmodule

// ==== read_mux.sv ====
`timescale 1ns/100ps

module read_mux (
  input  logic                       i_clk_bus,
  input  logic                       i_rst_n,
  periph_req_if.mon                  req,
  input  logic                       i_sys_ack,
  input  logic                       i_gpio_ack,
  input  logic [soc_pkg::DATA_W-1:0] i_sys_rdata,
  input  logic [soc_pkg::DATA_W-1:0] i_gpio_rdata,
  output logic [soc_pkg::DATA_W-1:0] o_rdata,
  output logic                       o_rvalid,
  output logic                       o_err
);

  logic r_bad_d;
  logic r_re_d;

  // Align request flags with the stage 2 acks
  always_ff @(posedge i_clk_bus or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_bad_d  <= 1'b0;
      r_re_d   <= 1'b0;
      o_rvalid <= 1'b0;
      o_err    <= 1'b0;
    end else begin
      r_bad_d  <= req.bad;
      r_re_d   <= req.re;
      o_rvalid <= i_sys_ack | i_gpio_ack | (r_bad_d & r_re_d);
      o_err    <= r_bad_d;
    end
  end

  // Bad read returns zero
  always_ff @(posedge i_clk_bus) begin
    if (i_sys_ack) begin
      o_rdata <= i_sys_rdata;
    end else if (i_gpio_ack) begin
      o_rdata <= i_gpio_rdata;
    end else begin
      o_rdata <= '0;
    end
  end

  a_ack_onehot: assert property (
    @(posedge i_clk_bus) disable iff (!i_rst_n) !(i_sys_ack && i_gpio_ack)
  );

  // A legal read must be acknowledged by exactly one peripheral
  a_read_acked: assert property (
    @(posedge i_clk_bus) disable iff (!i_rst_n)
      (r_re_d && !r_bad_d) |-> (i_sys_ack || i_gpio_ack)
  );

endmodule

// ==== fpga_top.sv ====
`timescale 1ns/100ps

module fpga_top #(
  parameter int LOCK_CYCLES = 16,
  parameter int GPIO_W      = 12
) (
  input  logic                       i_rst_n,
  input  logic                       i_sclk_p,
  input  logic                       i_sclk_n,
  input  logic                       i_bus_we,
  input  logic                       i_bus_re,
  input  logic [soc_pkg::ADDR_W-1:0] i_bus_addr,
  input  logic [soc_pkg::DATA_W-1:0] i_bus_wdata,
  output logic [soc_pkg::DATA_W-1:0] o_bus_rdata,
  output logic                       o_bus_rvalid,
  output logic                       o_bus_err,
  input  logic [GPIO_W-1:0]          i_gpio,
  output logic [GPIO_W-1:0]          o_gpio,
  output logic [GPIO_W-1:0]          o_gpio_dir,
  output logic                       o_sys_ready
);

  logic                       w_clk_bus;
  logic                       w_bus_nrst;
  logic                       w_sys_ack;
  logic                       w_gpio_ack;
  logic [soc_pkg::DATA_W-1:0] wb_sys_rdata;
  logic [soc_pkg::DATA_W-1:0] wb_gpio_rdata;

  periph_req_if w_req ();

  clk_rst_gen #(
    .LOCK_CYCLES(LOCK_CYCLES)
  ) pll0 (
    .i_sclk_p   (i_sclk_p),
    .i_sclk_n   (i_sclk_n),
    .i_rst_n    (i_rst_n),
    .o_clk_bus  (w_clk_bus),
    .o_bus_nrst (w_bus_nrst),
    .o_sys_ready(o_sys_ready)
  );

  bus_decode dec0 (
    .i_clk_bus(w_clk_bus),
    .i_rst_n  (w_bus_nrst),
    .i_we     (i_bus_we),
    .i_re     (i_bus_re),
    .i_addr   (i_bus_addr),
    .i_wdata  (i_bus_wdata),
    .req      (w_req.dec)
  );

  sys_regs sys0 (
    .i_clk_bus(w_clk_bus),
    .i_rst_n  (w_bus_nrst),
    .req      (w_req.periph),
    .o_ack    (w_sys_ack),
    .o_rdata  (wb_sys_rdata)
  );

  gpio_regs #(
    .GPIO_W(GPIO_W)
  ) gpio0 (
    .i_clk_bus (w_clk_bus),
    .i_rst_n   (w_bus_nrst),
    .req       (w_req.periph),
    .i_gpio    (i_gpio),
    .o_gpio    (o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .o_ack     (w_gpio_ack),
    .o_rdata   (wb_gpio_rdata)
  );

  read_mux rmux0 (
    .i_clk_bus   (w_clk_bus),
    .i_rst_n     (w_bus_nrst),
    .req         (w_req.mon),
    .i_sys_ack   (w_sys_ack),
    .i_gpio_ack  (w_gpio_ack),
    .i_sys_rdata (wb_sys_rdata),
    .i_gpio_rdata(wb_gpio_rdata),
    .o_rdata     (o_bus_rdata),
    .o_rvalid    (o_bus_rvalid),
    .o_err       (o_bus_err)
  );

endmodule

// ==== tb_fpga_top.sv ====
`timescale 1ns/100ps

module tb_fpga_top;

  localparam int LOCK_CYCLES = 16;
  localparam int GPIO_W      = 12;
  localparam int RESP_LAT    = 3;
  localparam int TIMEOUT     = 20;
  localparam int N_LOOPS     = 8;

  logic                       i_rst_n;
  logic                       i_sclk_p;
  logic                       i_sclk_n;
  logic                       i_bus_we;
  logic                       i_bus_re;
  logic [soc_pkg::ADDR_W-1:0] i_bus_addr;
  logic [soc_pkg::DATA_W-1:0] i_bus_wdata;
  logic [soc_pkg::DATA_W-1:0] o_bus_rdata;
  logic                       o_bus_rvalid;
  logic                       o_bus_err;
  logic [GPIO_W-1:0]          i_gpio;
  logic [GPIO_W-1:0]          o_gpio;
  logic [GPIO_W-1:0]          o_gpio_dir;
  logic                       o_sys_ready;

  int unsigned       errors;
  int unsigned       failures;
  int unsigned       bad_issued;
  // Expected pin output value, follows every OUT and SETCLR write
  logic [GPIO_W-1:0] exp_out;

  assign i_sclk_n = ~i_sclk_p;

  fpga_top #(
    .LOCK_CYCLES(LOCK_CYCLES),
    .GPIO_W     (GPIO_W)
  ) i_fpga_top (
    .i_rst_n     (i_rst_n),
    .i_sclk_p    (i_sclk_p),
    .i_sclk_n    (i_sclk_n),
    .i_bus_we    (i_bus_we),
    .i_bus_re    (i_bus_re),
    .i_bus_addr  (i_bus_addr),
    .i_bus_wdata (i_bus_wdata),
    .o_bus_rdata (o_bus_rdata),
    .o_bus_rvalid(o_bus_rvalid),
    .o_bus_err   (o_bus_err),
    .i_gpio      (i_gpio),
    .o_gpio      (o_gpio),
    .o_gpio_dir  (o_gpio_dir),
    .o_sys_ready (o_sys_ready)
  );

  initial begin
    i_sclk_p = 1'b0;
    forever #4 i_sclk_p = ~i_sclk_p;
  end

  function automatic logic [soc_pkg::ADDR_W-1:0] reg_addr(input logic [3:0] region,
                                                         input logic [3:0] offset);
    return {region, offset};
  endfunction

  task automatic check_data(input string name, input logic [soc_pkg::DATA_W-1:0] got,
                            input logic [soc_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_gpio(input string name, input logic [GPIO_W-1:0] got,
                            input logic [GPIO_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // All bus tasks start and end 1 ns after a rising edge
  task automatic bus_write(input logic [soc_pkg::ADDR_W-1:0] addr,
                           input logic [soc_pkg::DATA_W-1:0] data);
    i_bus_we    = 1'b1;
    i_bus_addr  = addr;
    i_bus_wdata = data;
    @(posedge i_sclk_p);
    #1;
    i_bus_we = 1'b0;
  endtask

  task automatic bus_read(input logic [soc_pkg::ADDR_W-1:0] addr,
                          output logic [soc_pkg::DATA_W-1:0] data, output logic err);
    int   n;
    logic got;
    n          = 0;
    got        = 1'b0;
    data       = '0;
    err        = 1'b0;
    i_bus_re   = 1'b1;
    i_bus_addr = addr;
    while (!got && (n < TIMEOUT)) begin
      @(posedge i_sclk_p);
      #1;
      i_bus_re = 1'b0;
      n++;
      if (o_bus_rvalid) begin
        got  = 1'b1;
        data = o_bus_rdata;
        err  = o_bus_err;
      end
    end
    if (!got) begin
      failures++;
      $display("Read of address %h got no response", addr);
    end else if (n != RESP_LAT) begin
      failures++;
      $display("Read of address %h answered after %0d clocks, not %0d", addr, n, RESP_LAT);
    end
  endtask

  // Illegal write, error pulse lands on the third clock after the strobe
  task automatic write_expect_err(input logic [soc_pkg::ADDR_W-1:0] addr,
                                  input logic [soc_pkg::DATA_W-1:0] data);
    int   n;
    logic got;
    n   = 1;
    got = 1'b0;
    bus_write(addr, data);
    while (!got && (n < TIMEOUT)) begin
      @(posedge i_sclk_p);
      #1;
      n++;
      if (o_bus_err) begin
        got = 1'b1;
        check_flag("o_bus_rvalid", o_bus_rvalid, 1'b0);
      end
    end
    if (!got) begin
      failures++;
      $display("Bad write to address %h raised no error", addr);
    end else if (n != RESP_LAT) begin
      failures++;
      $display("Bad write to address %h flagged after %0d clocks, not %0d", addr, n, RESP_LAT);
    end
  endtask

  task automatic wait_sys_ready();
    int n;
    n = 0;
    while (!o_sys_ready && (n < LOCK_CYCLES + TIMEOUT)) begin
      @(posedge i_sclk_p);
      #1;
      n++;
    end
  endtask

  task automatic check_reset_and_id();
    logic [soc_pkg::DATA_W-1:0] rval;
    logic                       err;
    check_gpio("o_gpio", o_gpio, '0);
    check_gpio("o_gpio_dir", o_gpio_dir, '0);
    check_flag("o_bus_rvalid", o_bus_rvalid, 1'b0);
    check_flag("o_bus_err", o_bus_err, 1'b0);
    bus_read(reg_addr(soc_pkg::REGION_SYS, soc_pkg::SYS_ID), rval, err);
    check_data("o_bus_rdata", rval, soc_pkg::SOC_ID);
    check_flag("o_bus_err", err, 1'b0);
  endtask

  // Each write is followed on the next clock by a read of the same register
  task automatic run_readback();
    logic [soc_pkg::DATA_W-1:0] wval;
    logic [soc_pkg::DATA_W-1:0] rval;
    logic                       err;
    for (int i = 0; i < N_LOOPS; i++) begin
      wval = $urandom();
      bus_write(reg_addr(soc_pkg::REGION_SYS, soc_pkg::SYS_SCRATCH), wval);
      bus_read(reg_addr(soc_pkg::REGION_SYS, soc_pkg::SYS_SCRATCH), rval, err);
      check_data("o_bus_rdata", rval, wval);
      check_flag("o_bus_err", err, 1'b0);

      wval = $urandom();
      bus_write(reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_DIR), wval);
      bus_read(reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_DIR), rval, err);
      check_data("o_bus_rdata", rval, soc_pkg::DATA_W'(wval[GPIO_W-1:0]));
      check_gpio("o_gpio_dir", o_gpio_dir, wval[GPIO_W-1:0]);

      wval = $urandom();
      exp_out = wval[GPIO_W-1:0];
      bus_write(reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OUT), wval);
      bus_read(reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OUT), rval, err);
      check_data("o_bus_rdata", rval, soc_pkg::DATA_W'(exp_out));
      check_gpio("o_gpio", o_gpio, exp_out);
    end
  endtask

  task automatic run_setclr();
    logic [15:0]                set_mask;
    logic [15:0]                clr_mask;
    logic [soc_pkg::DATA_W-1:0] rval;
    logic                       err;
    for (int i = 0; i < N_LOOPS; i++) begin
      set_mask = 16'($urandom());
      // Sparser clear mask so set bits survive
      clr_mask = 16'($urandom()) & 16'($urandom());
      exp_out  = (exp_out | set_mask[GPIO_W-1:0]) & ~clr_mask[GPIO_W-1:0];
      bus_write(reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_SETCLR), {clr_mask, set_mask});
      bus_read(reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_OUT), rval, err);
      check_data("o_bus_rdata", rval, soc_pkg::DATA_W'(exp_out));
      check_gpio("o_gpio", o_gpio, exp_out);
    end
  endtask

  task automatic run_gpio_input();
    logic [GPIO_W-1:0]          pins;
    logic [soc_pkg::DATA_W-1:0] rval;
    logic                       err;
    for (int i = 0; i < N_LOOPS; i++) begin
      pins   = GPIO_W'($urandom());
      i_gpio = pins;
      // Let the pins pass the synchronizer
      repeat (4) @(posedge i_sclk_p);
      #1;
      bus_read(reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_IN), rval, err);
      check_data("o_bus_rdata", rval, soc_pkg::DATA_W'(pins));
      check_flag("o_bus_err", err, 1'b0);
    end
  endtask

  task automatic run_bad_accesses();
    logic [soc_pkg::DATA_W-1:0] rval;
    logic                       err;
    bus_read(reg_addr(4'h2, 4'h0), rval, err);
    bad_issued++;
    check_data("o_bus_rdata", rval, '0);
    check_flag("o_bus_err", err, 1'b1);

    bus_read(reg_addr(soc_pkg::REGION_SYS, 4'h7), rval, err);
    bad_issued++;
    check_data("o_bus_rdata", rval, '0);
    check_flag("o_bus_err", err, 1'b1);

    write_expect_err(reg_addr(soc_pkg::REGION_SYS, soc_pkg::SYS_ID), $urandom());
    bad_issued++;

    bus_read(reg_addr(soc_pkg::REGION_GPIO, soc_pkg::GPIO_SETCLR), rval, err);
    bad_issued++;
    check_data("o_bus_rdata", rval, '0);
    check_flag("o_bus_err", err, 1'b1);

    bus_read(reg_addr(soc_pkg::REGION_SYS, soc_pkg::SYS_BADCNT), rval, err);
    check_data("o_bus_rdata", rval, bad_issued);
    check_flag("o_bus_err", err, 1'b0);
  endtask

  initial begin
    errors      = 0;
    failures    = 0;
    bad_issued  = 0;
    exp_out     = '0;
    i_rst_n     = 1'b0;
    i_bus_we    = 1'b0;
    i_bus_re    = 1'b0;
    i_bus_addr  = '0;
    i_bus_wdata = '0;
    i_gpio      = '0;
    void'($urandom(32'h8d32aba2));

    repeat (2) @(posedge i_sclk_p);
    #1;
    i_rst_n = 1'b1;
    wait_sys_ready();

    if (!o_sys_ready) begin
      failures++;
      $display("o_sys_ready never rose after reset");
    end else begin
      check_reset_and_id();
      run_readback();
      run_setclr();
      run_gpio_input();
      run_bad_accesses();
    end

    $display("Summary: %0d value mismatches, %0d other failures", errors, failures);
    if ((errors == 0) && (failures == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== fpga_top.f ====
soc_pkg.sv
soc_bus_if.sv
clk_rst_gen.sv
bus_decode.sv
sys_regs.sv
gpio_regs.sv
read_mux.sv
fpga_top.sv
tb_fpga_top.sv

// ==== Makefile ====
TOP := tb_fpga_top
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f fpga_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
